/* design/xpu_cfg.svh */
// xpu register map and defaults
`ifndef XPU_CFG_SVH
`define XPU_CFG_SVH

// register word addresses
`define XPU_REG_RST        6'd0
`define XPU_REG_TSF_LO     6'd2
// msb of the high word doubles as load control
`define XPU_REG_TSF_HI     6'd3
`define XPU_REG_BAND       6'd4
`define XPU_REG_TIMING     6'd9
`define XPU_REG_FILTER     6'd27
`define XPU_REG_MAC_LO     6'd30
`define XPU_REG_MAC_HI     6'd31
`define XPU_REG_TSF_RD_LO  6'd58
`define XPU_REG_TSF_RD_HI  6'd59
`define XPU_REG_VERSION    6'd63

// build identification word
`define XPU_VERSION        32'h4a2b_0107

// 20 ns clock, 50 cycles per microsecond
`define TSF_CLK_PER_US     50

// default interframe timings in us
`define DEF_PREAMBLE_SIG   20
`define DEF_OFDM_SYM       4
`define DEF_SLOT_SHORT     9
`define DEF_SLOT_LONG      20
`define DEF_SIFS_24G       10
`define DEF_SIFS_5G        16
`define DEF_RX_DELAY_24G   24
`define DEF_RX_DELAY_5G    25

// receive filter flag positions
`define FLT_PROMISC        0
`define FLT_BCAST          1
`define FLT_CTRL           2

// frame control type field value for control frames
`define FC_TYPE_CTRL       2'd1

`endif

/* design/xpu_pkg.sv */
// xpu shared types
package xpu_pkg;

    // register bus
    typedef logic [31:0] reg_data_t;
    typedef logic [5:0]  reg_addr_t;

    // 802.11 timing synchronization function, in us
    typedef logic [63:0] tsf_t;

    // station and frame addresses
    typedef logic [47:0] mac_addr_t;

    // demodulated byte stream
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] byte_idx_t;

    // frame control low half, duration high half
    typedef logic [31:0] fc_di_t;

    // radio settings
    // band code 1 is 2.4 GHz
    typedef logic [3:0]  band_t;
    typedef logic [7:0]  channel_t;

    // interframe quantities in us
    typedef logic [6:0]  time7_t;
    typedef logic [4:0]  time5_t;

    // promisc, bcast, ctrl flags
    typedef logic [3:0]  filter_cfg_t;

endpackage

/* design/xpu_regs.sv */
// xpu register bank
`timescale 1ns/1ps
`include "xpu_cfg.svh"

module xpu_regs
    import xpu_pkg::*;
(
    input  logic        s00_axi_aclk,
    input  logic        rst_i,
    input  logic        reg_wr_i,
    input  reg_addr_t   reg_addr_i,
    input  reg_data_t   reg_wdata_i,
    input  reg_addr_t   reg_rd_addr_i,
    input  tsf_t        tsf_runtime_val_i,
    output reg_data_t   reg_rd_data_o,
    output logic        parse_rst_o,
    output logic        filter_rst_o,
    output logic        tsf_load_ctl_o,
    output tsf_t        tsf_load_val_o,
    output band_t       band_o,
    output channel_t    channel_o,
    output time7_t      preamble_sig_time_o,
    output time7_t      sifs_time_o,
    output time7_t      phy_rx_start_delay_time_o,
    output time5_t      ofdm_symbol_time_o,
    output time5_t      slot_time_o,
    output filter_cfg_t filter_cfg_o,
    output mac_addr_t   mac_addr_o
);

    reg_data_t reg_rst;
    reg_data_t reg_tsf_lo;
    reg_data_t reg_tsf_hi;
    reg_data_t reg_band;
    reg_data_t reg_timing;
    reg_data_t reg_filter;
    reg_data_t reg_mac_lo;
    reg_data_t reg_mac_hi;

    logic short_slot;
    logic ovr_en;
    logic band_24g;

    // write port, one word per strobe
    always_ff @(posedge s00_axi_aclk) begin
        if (rst_i) begin
            reg_rst    <= '0;
            reg_tsf_lo <= '0;
            reg_tsf_hi <= '0;
            reg_band   <= '0;
            reg_timing <= '0;
            reg_filter <= '0;
            reg_mac_lo <= '0;
            reg_mac_hi <= '0;
        end else if (reg_wr_i) begin
            case (reg_addr_i)
                `XPU_REG_RST:    reg_rst    <= reg_wdata_i;
                `XPU_REG_TSF_LO: reg_tsf_lo <= reg_wdata_i;
                `XPU_REG_TSF_HI: reg_tsf_hi <= reg_wdata_i;
                `XPU_REG_BAND:   reg_band   <= reg_wdata_i;
                `XPU_REG_TIMING: reg_timing <= reg_wdata_i;
                `XPU_REG_FILTER: reg_filter <= reg_wdata_i;
                `XPU_REG_MAC_LO: reg_mac_lo <= reg_wdata_i;
                `XPU_REG_MAC_HI: reg_mac_hi <= reg_wdata_i;
                default:         ;
            endcase
        end
    end

    // registered read-back, unmapped words read zero
    always_ff @(posedge s00_axi_aclk) begin
        if (rst_i) begin
            reg_rd_data_o <= '0;
        end else begin
            case (reg_rd_addr_i)
                `XPU_REG_RST:       reg_rd_data_o <= reg_rst;
                `XPU_REG_TSF_LO:    reg_rd_data_o <= reg_tsf_lo;
                `XPU_REG_TSF_HI:    reg_rd_data_o <= reg_tsf_hi;
                `XPU_REG_BAND:      reg_rd_data_o <= reg_band;
                `XPU_REG_TIMING:    reg_rd_data_o <= reg_timing;
                `XPU_REG_FILTER:    reg_rd_data_o <= reg_filter;
                `XPU_REG_MAC_LO:    reg_rd_data_o <= reg_mac_lo;
                `XPU_REG_MAC_HI:    reg_rd_data_o <= reg_mac_hi;
                `XPU_REG_TSF_RD_LO: reg_rd_data_o <= tsf_runtime_val_i[31:0];
                `XPU_REG_TSF_RD_HI: reg_rd_data_o <= tsf_runtime_val_i[63:32];
                `XPU_REG_VERSION:   reg_rd_data_o <= `XPU_VERSION;
                default:            reg_rd_data_o <= '0;
            endcase
        end
    end

    // soft resets on top of the global one
    assign parse_rst_o  = rst_i | reg_rst[0];
    assign filter_rst_o = rst_i | reg_rst[1];

    // tsf load, msb rising edge is detected in the timer
    assign tsf_load_ctl_o = reg_tsf_hi[31];
    assign tsf_load_val_o = {reg_tsf_hi, reg_tsf_lo};

    assign band_o     = reg_band[19:16];
    assign channel_o  = reg_band[7:0];
    assign short_slot = reg_band[24];
    assign band_24g   = (band_o == band_t'(1));

    assign filter_cfg_o = reg_filter[3:0];
    assign mac_addr_o   = {reg_mac_hi[15:0], reg_mac_lo};

    // interframe timing, debug override wins over band defaults
    assign ovr_en = reg_timing[31];

    assign preamble_sig_time_o = ovr_en ? reg_timing[30:24] : time7_t'(`DEF_PREAMBLE_SIG);
    assign ofdm_symbol_time_o  = ovr_en ? reg_timing[23:19] : time5_t'(`DEF_OFDM_SYM);
    // long slot only for 2.4 GHz without erp short slot
    assign slot_time_o = ovr_en ? reg_timing[18:14] :
                         (band_24g && !short_slot) ? time5_t'(`DEF_SLOT_LONG) :
                         time5_t'(`DEF_SLOT_SHORT);
    assign sifs_time_o = ovr_en ? reg_timing[13:7] :
                         band_24g ? time7_t'(`DEF_SIFS_24G) : time7_t'(`DEF_SIFS_5G);
    assign phy_rx_start_delay_time_o = ovr_en ? reg_timing[6:0] :
                         band_24g ? time7_t'(`DEF_RX_DELAY_24G) : time7_t'(`DEF_RX_DELAY_5G);

endmodule

/* design/tsf_timer.sv */
// tsf microsecond timer
`timescale 1ns/1ps
`include "xpu_cfg.svh"

module tsf_timer
    import xpu_pkg::*;
(
    input  logic s00_axi_aclk,
    input  logic rst_i,
    input  logic tsf_load_ctl_i,
    input  tsf_t tsf_load_val_i,
    output tsf_t tsf_runtime_val_o,
    output logic tsf_pulse_1m_o
);

    localparam int unsigned DIV_W = $clog2(`TSF_CLK_PER_US);

    logic [DIV_W-1:0] div_cnt;
    logic             load_ctl_d;
    logic             load_rise;
    logic             div_wrap;

    assign load_rise = tsf_load_ctl_i & ~load_ctl_d;
    // last clock of each microsecond
    assign div_wrap  = (div_cnt == DIV_W'(`TSF_CLK_PER_US - 1));

    always_ff @(posedge s00_axi_aclk) begin
        if (rst_i) begin
            load_ctl_d        <= 1'b0;
            div_cnt           <= '0;
            tsf_runtime_val_o <= '0;
            tsf_pulse_1m_o    <= 1'b0;
        end else begin
            load_ctl_d <= tsf_load_ctl_i;
            if (load_rise) begin
                // new epoch, divider starts over
                div_cnt           <= '0;
                tsf_runtime_val_o <= tsf_load_val_i;
                tsf_pulse_1m_o    <= 1'b0;
            end else if (div_wrap) begin
                div_cnt           <= '0;
                tsf_runtime_val_o <= tsf_runtime_val_o + 64'd1;
                tsf_pulse_1m_o    <= 1'b1;
            end else begin
                div_cnt        <= div_cnt + 1'b1;
                tsf_pulse_1m_o <= 1'b0;
            end
        end
    end

endmodule

/* design/phy_rx_parse.sv */
// mac header field parser
`timescale 1ns/1ps

module phy_rx_parse
    import xpu_pkg::*;
(
    input  logic      s00_axi_aclk,
    input  logic      rst_i,
    input  logic      pkt_header_valid_strobe_i,
    input  byte_t     byte_in_i,
    input  byte_idx_t byte_count_i,
    input  logic      byte_in_strobe_i,
    output fc_di_t    fc_di_o,
    output logic      fc_di_valid_o,
    output mac_addr_t addr1_o,
    output mac_addr_t addr2_o,
    output mac_addr_t addr3_o,
    output logic      addr1_valid_o,
    output logic      addr2_valid_o,
    output logic      addr3_valid_o
);

    // last byte index of each field
    localparam byte_idx_t FC_LAST = 16'd3;
    localparam byte_idx_t A1_LAST = 16'd9;
    localparam byte_idx_t A2_LAST = 16'd15;
    localparam byte_idx_t A3_LAST = 16'd21;

    logic       in_fc;
    logic       in_a1;
    logic       in_a2;
    logic       in_a3;
    logic [3:0] last_hit;
    logic [3:0] field_done;

    // field select by byte index
    assign in_fc = (byte_count_i <= FC_LAST);
    assign in_a1 = (byte_count_i > FC_LAST) && (byte_count_i <= A1_LAST);
    assign in_a2 = (byte_count_i > A1_LAST) && (byte_count_i <= A2_LAST);
    assign in_a3 = (byte_count_i > A2_LAST) && (byte_count_i <= A3_LAST);

    assign last_hit[0] = byte_in_strobe_i && (byte_count_i == FC_LAST);
    assign last_hit[1] = byte_in_strobe_i && (byte_count_i == A1_LAST);
    assign last_hit[2] = byte_in_strobe_i && (byte_count_i == A2_LAST);
    assign last_hit[3] = byte_in_strobe_i && (byte_count_i == A3_LAST);

    // little endian, newest byte enters at the top
    always_ff @(posedge s00_axi_aclk) begin
        if (byte_in_strobe_i) begin
            if (in_fc)
                fc_di_o <= {byte_in_i, fc_di_o[31:8]};
            if (in_a1)
                addr1_o <= {byte_in_i, addr1_o[47:8]};
            if (in_a2)
                addr2_o <= {byte_in_i, addr2_o[47:8]};
            if (in_a3)
                addr3_o <= {byte_in_i, addr3_o[47:8]};
        end
    end

    // one valid pulse per field and frame
    always_ff @(posedge s00_axi_aclk) begin
        if (rst_i) begin
            field_done <= '0;
            {addr3_valid_o, addr2_valid_o, addr1_valid_o, fc_di_valid_o} <= '0;
        end else begin
            {addr3_valid_o, addr2_valid_o, addr1_valid_o, fc_di_valid_o} <=
                last_hit & ~field_done;
            // new header, rearm all fields
            if (pkt_header_valid_strobe_i)
                field_done <= '0;
            else
                field_done <= field_done | last_hit;
        end
    end

endmodule

/* design/pkt_filter_ctl.sv */
// receive dma filter
`timescale 1ns/1ps
`include "xpu_cfg.svh"

module pkt_filter_ctl
    import xpu_pkg::*;
(
    input  logic        s00_axi_aclk,
    input  logic        rst_i,
    input  filter_cfg_t filter_cfg_i,
    input  mac_addr_t   self_mac_addr_i,
    input  logic [1:0]  fc_type_i,
    input  mac_addr_t   addr1_i,
    input  logic        addr1_valid_i,
    output logic        block_rx_dma_to_ps_o,
    output logic        block_rx_dma_to_ps_valid_o
);

    logic own_hit;
    logic bcast_hit;
    logic ctrl_type;
    logic pass;

    assign own_hit   = (addr1_i == self_mac_addr_i);
    assign bcast_hit = &addr1_i;
    assign ctrl_type = (fc_type_i == `FC_TYPE_CTRL);

    // first matching class decides
    always_comb begin
        if (own_hit)
            pass = 1'b1;
        else if (bcast_hit)
            pass = filter_cfg_i[`FLT_BCAST];
        else if (ctrl_type)
            pass = filter_cfg_i[`FLT_CTRL];
        else
            pass = filter_cfg_i[`FLT_PROMISC];
    end

    // block level holds until the next frame's addr1
    always_ff @(posedge s00_axi_aclk) begin
        if (rst_i) begin
            block_rx_dma_to_ps_o       <= 1'b0;
            block_rx_dma_to_ps_valid_o <= 1'b0;
        end else begin
            block_rx_dma_to_ps_valid_o <= addr1_valid_i;
            if (addr1_valid_i)
                block_rx_dma_to_ps_o <= ~pass;
        end
    end

endmodule

/* design/xpu.sv */
// xpu receive core top
`timescale 1ns/1ps

module xpu
    import xpu_pkg::*;
(
    input  logic      s00_axi_aclk,
    input  logic      rst_i,
    // register access
    input  logic      reg_wr_i,
    input  reg_addr_t reg_addr_i,
    input  reg_data_t reg_wdata_i,
    input  reg_addr_t reg_rd_addr_i,
    output reg_data_t reg_rd_data_o,
    // demodulated byte stream
    input  byte_t     byte_in_i,
    input  byte_idx_t byte_count_i,
    input  logic      byte_in_strobe_i,
    input  logic      pkt_header_valid_strobe_i,
    // tsf
    output tsf_t      tsf_runtime_val_o,
    output logic      tsf_pulse_1m_o,
    // radio and timing settings
    output band_t     band_o,
    output channel_t  channel_o,
    output time7_t    preamble_sig_time_o,
    output time5_t    ofdm_symbol_time_o,
    output time5_t    slot_time_o,
    output time7_t    sifs_time_o,
    output time7_t    phy_rx_start_delay_time_o,
    output mac_addr_t mac_addr_o,
    // dma gate toward the processor
    output logic      block_rx_dma_to_ps_o,
    output logic      block_rx_dma_to_ps_valid_o
);

    logic        parse_rst;
    logic        filter_rst;
    logic        tsf_load_ctl;
    tsf_t        tsf_load_val;
    filter_cfg_t filter_cfg;
    fc_di_t      fc_di;
    mac_addr_t   addr1;
    logic        addr1_valid;

    xpu_regs xpu_regs_i (
        .s00_axi_aclk              (s00_axi_aclk),
        .rst_i                     (rst_i),
        .reg_wr_i                  (reg_wr_i),
        .reg_addr_i                (reg_addr_i),
        .reg_wdata_i               (reg_wdata_i),
        .reg_rd_addr_i             (reg_rd_addr_i),
        .tsf_runtime_val_i         (tsf_runtime_val_o),
        .reg_rd_data_o             (reg_rd_data_o),
        .parse_rst_o               (parse_rst),
        .filter_rst_o              (filter_rst),
        .tsf_load_ctl_o            (tsf_load_ctl),
        .tsf_load_val_o            (tsf_load_val),
        .band_o                    (band_o),
        .channel_o                 (channel_o),
        .preamble_sig_time_o       (preamble_sig_time_o),
        .sifs_time_o               (sifs_time_o),
        .phy_rx_start_delay_time_o (phy_rx_start_delay_time_o),
        .ofdm_symbol_time_o        (ofdm_symbol_time_o),
        .slot_time_o               (slot_time_o),
        .filter_cfg_o              (filter_cfg),
        .mac_addr_o                (mac_addr_o)
    );

    tsf_timer tsf_timer_i (
        .s00_axi_aclk      (s00_axi_aclk),
        .rst_i             (rst_i),
        .tsf_load_ctl_i    (tsf_load_ctl),
        .tsf_load_val_i    (tsf_load_val),
        .tsf_runtime_val_o (tsf_runtime_val_o),
        .tsf_pulse_1m_o    (tsf_pulse_1m_o)
    );

    // only fc and addr1 feed the filter here
    phy_rx_parse phy_rx_parse_i (
        .s00_axi_aclk              (s00_axi_aclk),
        .rst_i                     (parse_rst),
        .pkt_header_valid_strobe_i (pkt_header_valid_strobe_i),
        .byte_in_i                 (byte_in_i),
        .byte_count_i              (byte_count_i),
        .byte_in_strobe_i          (byte_in_strobe_i),
        .fc_di_o                   (fc_di),
        .fc_di_valid_o             (),
        .addr1_o                   (addr1),
        .addr2_o                   (),
        .addr3_o                   (),
        .addr1_valid_o             (addr1_valid),
        .addr2_valid_o             (),
        .addr3_valid_o             ()
    );

    pkt_filter_ctl pkt_filter_ctl_i (
        .s00_axi_aclk               (s00_axi_aclk),
        .rst_i                      (filter_rst),
        .filter_cfg_i               (filter_cfg),
        .self_mac_addr_i            (mac_addr_o),
        .fc_type_i                  (fc_di[3:2]),
        .addr1_i                    (addr1),
        .addr1_valid_i              (addr1_valid),
        .block_rx_dma_to_ps_o       (block_rx_dma_to_ps_o),
        .block_rx_dma_to_ps_valid_o (block_rx_dma_to_ps_valid_o)
    );

endmodule

/* test/tb_xpu.sv */
// xpu receive core testbench
`timescale 1ns/1ps
`include "xpu_cfg.svh"

module tb_xpu
    import xpu_pkg::*;
();

    // sum of test lengths plus margin
    localparam int MAX_CYCLES = 6000;

    logic      s00_axi_aclk;
    logic      rst_i;
    logic      reg_wr_i;
    reg_addr_t reg_addr_i;
    reg_data_t reg_wdata_i;
    reg_addr_t reg_rd_addr_i;
    reg_data_t reg_rd_data_o;
    byte_t     byte_in_i;
    byte_idx_t byte_count_i;
    logic      byte_in_strobe_i;
    logic      pkt_header_valid_strobe_i;
    tsf_t      tsf_runtime_val_o;
    logic      tsf_pulse_1m_o;
    band_t     band_o;
    channel_t  channel_o;
    time7_t    preamble_sig_time_o;
    time5_t    ofdm_symbol_time_o;
    time5_t    slot_time_o;
    time7_t    sifs_time_o;
    time7_t    phy_rx_start_delay_time_o;
    mac_addr_t mac_addr_o;
    logic      block_rx_dma_to_ps_o;
    logic      block_rx_dma_to_ps_valid_o;

    integer      seed;
    int          errors;
    int          cycles;
    byte_t       hdr [0:21];
    mac_addr_t   self_mac;
    filter_cfg_t cur_cfg;
    logic        exp_block;
    int          exp_fc, exp_a1, exp_a2, exp_a3, exp_blk;
    int          seen_fc, seen_a1, seen_a2, seen_a3, seen_blk;
    int          b, s, f, i, k, cfg, t;
    reg_data_t   word_a, word_b, word_c, rd;
    logic [30:0] tm_exp, tm_act;
    tsf_t        tsf_load, tsf_exp;
    mac_addr_t   a1;

    xpu dut (.*);

    // parser valid pulses tapped inside the top level
    logic fc_valid;
    logic a1_valid;
    logic a2_valid;
    logic a3_valid;
    assign fc_valid = dut.phy_rx_parse_i.fc_di_valid_o;
    assign a1_valid = dut.phy_rx_parse_i.addr1_valid_o;
    assign a2_valid = dut.phy_rx_parse_i.addr2_valid_o;
    assign a3_valid = dut.phy_rx_parse_i.addr3_valid_o;

    initial begin
        s00_axi_aclk = 1'b0;
        forever #10 s00_axi_aclk = ~s00_axi_aclk;
    end

    // little-endian assembly of header bytes
    function automatic logic [47:0] field_value(input int first, input int len);
        logic [47:0] val;
        int          n;
        val = '0;
        for (n = 0; n < len; n++)
            val[8*n +: 8] = hdr[first + n];
        return val;
    endfunction

    // {preamble, symbol, slot, sifs, rx delay}
    function automatic logic [30:0] timing_ref(input int band, input int short_slot,
                                               input reg_data_t ovr);
        time7_t pre, sifs, rxd;
        time5_t sym, slot;
        if (ovr[31]) begin
            {pre, sym, slot, sifs, rxd} = {ovr[30:24], ovr[23:19], ovr[18:14], ovr[13:7],
                                           ovr[6:0]};
        end else begin
            pre  = `DEF_PREAMBLE_SIG;
            sym  = `DEF_OFDM_SYM;
            slot = (band == 1 && short_slot == 0) ? `DEF_SLOT_LONG : `DEF_SLOT_SHORT;
            sifs = (band == 1) ? `DEF_SIFS_24G : `DEF_SIFS_5G;
            rxd  = (band == 1) ? `DEF_RX_DELAY_24G : `DEF_RX_DELAY_5G;
        end
        return {pre, sym, slot, sifs, rxd};
    endfunction

    // 1 means blocked from dma
    function automatic logic filter_ref(input filter_cfg_t fcfg, input mac_addr_t self,
                                        input logic [1:0] ftype, input mac_addr_t addr);
        logic pass;
        if (addr == self)
            pass = 1'b1;
        else if (addr == 48'hffff_ffff_ffff)
            pass = fcfg[`FLT_BCAST];
        else if (ftype == `FC_TYPE_CTRL)
            pass = fcfg[`FLT_CTRL];
        else
            pass = fcfg[`FLT_PROMISC];
        return !pass;
    endfunction

    task report_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
        errors++;
        $display("Fail %s: expected %h, actual %h", name, exp, act);
    endtask

    task note_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task write_reg(input reg_addr_t addr, input reg_data_t data);
        @(negedge s00_axi_aclk);
        reg_wr_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge s00_axi_aclk);
        reg_wr_i = 1'b0;
    endtask

    task read_reg(input reg_addr_t addr, output reg_data_t data);
        @(negedge s00_axi_aclk);
        reg_rd_addr_i = addr;
        @(negedge s00_axi_aclk);
        data = reg_rd_data_o;
    endtask

    // header strobe, then hdr bytes with random gaps
    task send_frame(input int nbytes, input int gap_max);
        int n;
        int gap;
        int cyc;
        if (nbytes >= 4) exp_fc++;
        if (nbytes >= 10) exp_a1++;
        if (nbytes >= 10) exp_blk++;
        if (nbytes >= 16) exp_a2++;
        if (nbytes >= 22) exp_a3++;
        exp_block = filter_ref(cur_cfg, self_mac, hdr[0][3:2], field_value(4, 6));
        @(negedge s00_axi_aclk);
        pkt_header_valid_strobe_i = 1'b1;
        @(negedge s00_axi_aclk);
        pkt_header_valid_strobe_i = 1'b0;
        for (n = 0; n < nbytes; n++) begin
            byte_in_i        = hdr[n];
            byte_count_i     = byte_idx_t'(n);
            byte_in_strobe_i = 1'b1;
            @(negedge s00_axi_aclk);
            byte_in_strobe_i = 1'b0;
            gap = $unsigned($random(seed)) % (gap_max + 1);
            repeat (gap) @(negedge s00_axi_aclk);
        end
        // bounded wait for the trailing pulses
        cyc = 0;
        while ((seen_fc != exp_fc || seen_a1 != exp_a1 || seen_a2 != exp_a2 ||
                seen_a3 != exp_a3 || seen_blk != exp_blk) && cyc < 12) begin
            @(negedge s00_axi_aclk);
            cyc++;
        end
        @(negedge s00_axi_aclk);
        // negedge counts are settled by the next posedge
        @(posedge s00_axi_aclk);
        if (seen_fc != exp_fc || seen_a1 != exp_a1 || seen_a2 != exp_a2 ||
            seen_a3 != exp_a3 || seen_blk != exp_blk) begin
            note_error("a field or filter valid pulse was missing or repeated for a header");
            {seen_fc, seen_a1, seen_a2, seen_a3} = {exp_fc, exp_a1, exp_a2, exp_a3};
            seen_blk = exp_blk;
        end
    endtask

    // compare on each valid pulse at mid cycle
    always @(negedge s00_axi_aclk) begin
        if (fc_valid === 1'b1) begin
            seen_fc++;
            if (dut.phy_rx_parse_i.fc_di_o !== field_value(0, 4))
                report_mismatch("parse fc_di", field_value(0, 4), dut.phy_rx_parse_i.fc_di_o);
        end
        if (a1_valid === 1'b1) begin
            seen_a1++;
            if (dut.phy_rx_parse_i.addr1_o !== field_value(4, 6))
                report_mismatch("parse addr1", field_value(4, 6), dut.phy_rx_parse_i.addr1_o);
        end
        if (a2_valid === 1'b1) begin
            seen_a2++;
            if (dut.phy_rx_parse_i.addr2_o !== field_value(10, 6))
                report_mismatch("parse addr2", field_value(10, 6), dut.phy_rx_parse_i.addr2_o);
        end
        if (a3_valid === 1'b1) begin
            seen_a3++;
            if (dut.phy_rx_parse_i.addr3_o !== field_value(16, 6))
                report_mismatch("parse addr3", field_value(16, 6), dut.phy_rx_parse_i.addr3_o);
        end
        if (block_rx_dma_to_ps_valid_o === 1'b1) begin
            seen_blk++;
            if (block_rx_dma_to_ps_o !== exp_block)
                report_mismatch("filter block", exp_block, block_rx_dma_to_ps_o);
        end
    end

    // watchdog
    always @(posedge s00_axi_aclk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        seed   = 7812;
        errors = 0;
        cycles = 0;
        {exp_fc, exp_a1, exp_a2, exp_a3, exp_blk} = '0;
        {seen_fc, seen_a1, seen_a2, seen_a3, seen_blk} = '0;
        rst_i = 1'b1;
        reg_wr_i = 1'b0;
        reg_addr_i = '0;
        reg_wdata_i = '0;
        reg_rd_addr_i = '0;
        byte_in_i = '0;
        byte_count_i = '0;
        byte_in_strobe_i = 1'b0;
        pkt_header_valid_strobe_i = 1'b0;
        repeat (4) @(negedge s00_axi_aclk);
        rst_i = 1'b0;
        @(negedge s00_axi_aclk);
        if (block_rx_dma_to_ps_o !== 1'b0 || block_rx_dma_to_ps_valid_o !== 1'b0)
            note_error("filter block outputs are not low after reset");

        // register readback
        word_a = $random(seed);
        word_b = $random(seed);
        word_c = $random(seed);
        write_reg(`XPU_REG_MAC_LO, word_a);
        write_reg(`XPU_REG_MAC_HI, word_b);
        write_reg(`XPU_REG_FILTER, word_c);
        self_mac = {word_b[15:0], word_a};
        cur_cfg  = word_c[3:0];
        read_reg(`XPU_REG_MAC_LO, rd);
        if (rd !== word_a) report_mismatch("readback mac_lo", word_a, rd);
        read_reg(`XPU_REG_MAC_HI, rd);
        if (rd !== word_b) report_mismatch("readback mac_hi", word_b, rd);
        read_reg(`XPU_REG_FILTER, rd);
        if (rd !== word_c) report_mismatch("readback filter", word_c, rd);
        read_reg(`XPU_REG_VERSION, rd);
        if (rd !== `XPU_VERSION) report_mismatch("readback version", `XPU_VERSION, rd);
        read_reg(6'd40, rd);
        if (rd !== 32'd0) report_mismatch("readback unused", 0, rd);
        if (mac_addr_o !== self_mac) report_mismatch("mac_addr_o", self_mac, mac_addr_o);

        // timing defaults per band and slot, then random overrides
        for (b = 1; b <= 2; b++) begin
            for (s = 0; s < 2; s++) begin
                word_a = $random(seed);
                write_reg(`XPU_REG_TIMING, 32'd0);
                write_reg(`XPU_REG_BAND, {7'd0, s[0], 4'd0, b[3:0], 8'd0, word_a[7:0]});
                tm_exp = timing_ref(b, s, 32'd0);
                tm_act = {preamble_sig_time_o, ofdm_symbol_time_o, slot_time_o, sifs_time_o,
                          phy_rx_start_delay_time_o};
                if (tm_act !== tm_exp) report_mismatch("timing default", tm_exp, tm_act);
                if (band_o !== b[3:0]) report_mismatch("band", b, band_o);
                if (channel_o !== word_a[7:0]) report_mismatch("channel", word_a[7:0], channel_o);
                word_b = $random(seed);
                word_b[31] = 1'b1;
                write_reg(`XPU_REG_TIMING, word_b);
                tm_exp = timing_ref(b, s, word_b);
                tm_act = {preamble_sig_time_o, ofdm_symbol_time_o, slot_time_o, sifs_time_o,
                          phy_rx_start_delay_time_o};
                if (tm_act !== tm_exp) report_mismatch("timing override", tm_exp, tm_act);
            end
        end

        // tsf load on msb rise, then ten ticks
        word_a = $random(seed);
        word_b = $random(seed);
        word_b[31] = 1'b1;
        write_reg(`XPU_REG_TSF_LO, word_a);
        write_reg(`XPU_REG_TSF_HI, word_b);
        tsf_load = {word_b, word_a};
        @(negedge s00_axi_aclk);
        if (tsf_runtime_val_o !== tsf_load)
            report_mismatch("tsf load", tsf_load, tsf_runtime_val_o);
        // one tick pulse at the end of every microsecond
        for (i = 1; i <= 10 * `TSF_CLK_PER_US; i++) begin
            @(negedge s00_axi_aclk);
            if (tsf_pulse_1m_o !== (i % `TSF_CLK_PER_US == 0))
                report_mismatch("tsf pulse", (i % `TSF_CLK_PER_US == 0), tsf_pulse_1m_o);
        end
        tsf_exp = tsf_load + 64'd10;
        if (tsf_runtime_val_o !== tsf_exp)
            report_mismatch("tsf count", tsf_exp, tsf_runtime_val_o);
        reg_rd_addr_i = `XPU_REG_TSF_RD_LO;
        @(negedge s00_axi_aclk);
        if (reg_rd_data_o !== tsf_exp[31:0])
            report_mismatch("tsf read lo", tsf_exp[31:0], reg_rd_data_o);
        reg_rd_addr_i = `XPU_REG_TSF_RD_HI;
        @(negedge s00_axi_aclk);
        if (reg_rd_data_o !== tsf_exp[63:32])
            report_mismatch("tsf read hi", tsf_exp[63:32], reg_rd_data_o);

        // full random headers with gaps
        for (f = 0; f < 8; f++) begin
            for (i = 0; i < 22; i++)
                hdr[i] = $random(seed);
            send_frame(22, 3);
        end

        // own, broadcast and other address under every flag set and type
        for (k = 0; k < 3; k++) begin
            for (cfg = 0; cfg < 8; cfg++) begin
                for (t = 1; t <= 2; t++) begin
                    write_reg(`XPU_REG_FILTER, cfg);
                    cur_cfg = cfg[3:0];
                    word_a = $random(seed);
                    word_b = $random(seed);
                    a1 = (k == 0) ? self_mac : (k == 1) ? 48'hffff_ffff_ffff
                                                        : {word_a[15:0], word_b};
                    if (k == 2 && (a1 == self_mac || &a1))
                        a1[0] = ~a1[0];
                    // type sits in bits 3:2 of the first fc byte
                    hdr[0] = {word_a[31:28], t[1:0], 2'b00};
                    for (i = 1; i < 4; i++)
                        hdr[i] = $random(seed);
                    for (i = 0; i < 6; i++)
                        hdr[4 + i] = a1[8*i +: 8];
                    send_frame(10, 0);
                end
            end
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/xpu_pkg.sv
design/xpu_regs.sv
design/tsf_timer.sv
design/phy_rx_parse.sv
design/pkt_filter_ctl.sv
design/xpu.sv
test/tb_xpu.sv
